// ==== verilog/rob_pkg.sv ====
package rob_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int XLEN     = 64;  // data and address width
    localparam int TAG_W    = 8;   // tag field width, low bits index the rob
    localparam int NUM_REGS = 32;  // architectural registers, x0 included

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    // what kind of instruction sits in a rob slot
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,  // plain register write
        OP_STORE  = 2'd1,  // drives store address, no register write
        OP_BRANCH = 2'd2   // may flush younger work when it retires
    } rob_op_e;

    // life of one rob slot
    typedef enum logic [1:0] {
        ENTRY_FREE   = 2'd0,  // slot unused
        ENTRY_ISSUED = 2'd1,  // dispatched, waiting on a result
        ENTRY_DONE   = 2'd2   // result in, may retire once at head
    } entry_state_e;

    ////////////////////////////////////////
    // packets
    ////////////////////////////////////////

    // dispatch side, arrives in program order
    typedef struct packed {
        rob_op_e  op;        // instruction class
        reg_idx_t dest_reg;  // 0 for stores
    } dispatch_packet_t;

    // completion side, any order
    typedef struct packed {
        logic [TAG_W-1:0] tag;         // only low log2(depth) bits matter
        logic [XLEN-1:0]  value;       // result for the register write
        logic [XLEN-1:0]  mem_addr;    // store address, ignored otherwise
        logic             mispredict;  // branch went the wrong way
    } complete_packet_t;

    // head of the rob toward the retire stage
    typedef struct packed {
        logic [XLEN-1:0] value;      // result to commit
        reg_idx_t        dest_reg;   // destination register
        logic [XLEN-1:0] mem_addr;   // store address
        logic            mem_valid;  // set for OP_STORE
    } rob_retire_packet_t;

endpackage

// ==== verilog/rob.sv ====
`timescale 1ns/100ps

module rob import rob_pkg::*; #(
    parameter int ROB_DEPTH = 8  // power of two, 4 to 64
) (
    input  logic               clock,
    input  logic               rst_n,

    // dispatch, program order
    input  logic               dispatch_valid,
    input  dispatch_packet_t   dispatch_packet,
    output logic [TAG_W-1:0]   dispatch_tag,       // tail index, comb
    output logic               rob_full,           // level, source must hold

    // completion, any order
    input  logic               complete_valid,
    input  complete_packet_t   complete_packet,

    // head toward the retire stage
    output rob_retire_packet_t rob_retire_packet,
    output logic               rob_valid,          // head occupied
    output logic               rob_ready,          // head done
    output logic               branch_mispredict   // one cycle flush pulse
);

    localparam int IDX_W = $clog2(ROB_DEPTH);

    ////////////////////////////////////////
    // pointers and entry storage
    ////////////////////////////////////////

    // one extra msb as wrap bit
    logic [IDX_W:0]   head;
    logic [IDX_W:0]   tail;
    logic [IDX_W-1:0] head_idx;
    logic [IDX_W-1:0] tail_idx;
    logic [IDX_W-1:0] cmp_idx;  // completion slot

    entry_state_e     entry_state [ROB_DEPTH];  // control, reset
    rob_op_e          entry_op    [ROB_DEPTH];  // payload from here on
    reg_idx_t         entry_dest  [ROB_DEPTH];
    logic [XLEN-1:0]  entry_value [ROB_DEPTH];
    logic [XLEN-1:0]  entry_addr  [ROB_DEPTH];
    logic             entry_mis   [ROB_DEPTH];

    logic             rob_empty;
    logic             all_used;     // every slot occupied
    logic             do_dispatch;
    logic             do_complete;
    logic             do_retire;
    logic             flush;        // mispredicted branch leaving now

    assign head_idx = head[IDX_W-1:0];
    assign tail_idx = tail[IDX_W-1:0];
    assign cmp_idx  = complete_packet.tag[IDX_W-1:0];  // upper tag bits unused

    // same index, wrap bits tell full from empty
    assign rob_empty = (head == tail);
    assign all_used  = (head_idx == tail_idx) && (head[IDX_W] != tail[IDX_W]);

    assign rob_full     = all_used || branch_mispredict;  // no dispatch while flushing
    assign dispatch_tag = {{(TAG_W-IDX_W){1'b0}}, tail_idx};

    assign rob_valid = !rob_empty;
    assign rob_ready = (entry_state[head_idx] == ENTRY_DONE);

    ////////////////////////////////////////
    // strobes for this edge
    ////////////////////////////////////////

    assign do_dispatch = dispatch_valid && !rob_full;
    assign do_complete = complete_valid && (entry_state[cmp_idx] == ENTRY_ISSUED);  // free or done ignored
    assign do_retire   = rob_valid && rob_ready;
    assign flush       = do_retire && entry_mis[head_idx];

    // head packet, stores flagged by opcode
    always_comb begin
        rob_retire_packet.value     = entry_value[head_idx];
        rob_retire_packet.dest_reg  = entry_dest[head_idx];
        rob_retire_packet.mem_addr  = entry_addr[head_idx];
        rob_retire_packet.mem_valid = (entry_op[head_idx] == OP_STORE);
    end

    ////////////////////////////////////////
    // control state
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head              <= '0;
            tail              <= '0;
            branch_mispredict <= 1'b0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entry_state[i] <= ENTRY_FREE;
            end
        end else begin
            branch_mispredict <= flush;  // high exactly one cycle
            if (flush) begin
                // wipe everything younger than the branch, incl. a same-edge dispatch
                head <= '0;
                tail <= '0;
                for (int i = 0; i < ROB_DEPTH; i++) begin
                    entry_state[i] <= ENTRY_FREE;
                end
            end else begin
                // the three slots below never collide
                if (do_complete) begin
                    entry_state[cmp_idx] <= ENTRY_DONE;
                end
                if (do_retire) begin
                    entry_state[head_idx] <= ENTRY_FREE;
                    head                  <= head + 1'b1;  // wraps with msb toggle
                end
                if (do_dispatch) begin
                    entry_state[tail_idx] <= ENTRY_ISSUED;
                    tail                  <= tail + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // payload
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (do_dispatch) begin
            entry_op[tail_idx]   <= dispatch_packet.op;
            entry_dest[tail_idx] <= dispatch_packet.dest_reg;
        end
        if (do_complete) begin
            entry_value[cmp_idx] <= complete_packet.value;
            entry_addr[cmp_idx]  <= complete_packet.mem_addr;
            entry_mis[cmp_idx]   <= complete_packet.mispredict;  // read only once done
        end
    end

endmodule

// ==== verilog/stage_rt.sv ====
`timescale 1ns/100ps

module stage_rt import rob_pkg::*; (
    input  logic               clock,
    input  logic               rst_n,

    // from the rob head
    input  rob_retire_packet_t rob_retire_packet,
    input  logic               rob_ready,          // head entry done
    input  logic               rob_valid,          // head entry occupied

    // commit control
    input  logic               branch_mispredict,  // flush pulse from rob

    // register file write
    output logic [XLEN-1:0]    retire_value,
    output reg_idx_t           retire_dest,
    output logic               retire_valid_out,

    // store side
    output logic [XLEN-1:0]    mem_addr,
    output logic               mem_valid
);

    logic take;  // head leaves the rob on this edge

    assign take = rob_ready && rob_valid;

    ////////////////////////////////////////
    // one cycle retire register
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            retire_value     <= '0;
            retire_dest      <= '0;
            retire_valid_out <= 1'b0;
            mem_addr         <= '0;
            mem_valid        <= 1'b0;
        end else if (branch_mispredict) begin
            // flush cycle, drop whatever is shown
            retire_value     <= '0;
            retire_dest      <= '0;
            retire_valid_out <= 1'b0;
            mem_addr         <= '0;
            mem_valid        <= 1'b0;
        end else if (take) begin
            retire_value     <= rob_retire_packet.value;
            retire_dest      <= rob_retire_packet.dest_reg;  // 0 for stores
            retire_valid_out <= 1'b1;
            mem_addr         <= rob_retire_packet.mem_addr;
            mem_valid        <= rob_retire_packet.mem_valid;
        end else begin
            // idle, all outputs back to zero
            retire_value     <= '0;
            retire_dest      <= '0;
            retire_valid_out <= 1'b0;
            mem_addr         <= '0;
            mem_valid        <= 1'b0;
        end
    end

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/100ps

module regfile import rob_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,

    // write port, from retire
    input  logic            write_en,
    input  reg_idx_t        write_idx,
    input  logic [XLEN-1:0] write_data,

    // read port, combinational
    input  reg_idx_t        read_idx,
    output logic [XLEN-1:0] read_data
);

    ////////////////////////////////////////
    // storage, x1 to x31
    ////////////////////////////////////////

    logic [XLEN-1:0] regs [1:NUM_REGS-1];  // no slot for x0
    logic            wr_hit;               // write to a real register

    assign wr_hit = write_en && (write_idx != '0);  // x0 writes dropped

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[write_idx] <= write_data;
        end
    end

    ////////////////////////////////////////
    // read
    ////////////////////////////////////////

    // no bypass, a write shows up the cycle after its edge
    always_comb begin
        if (read_idx == '0) begin
            read_data = '0;  // hard-wired zero
        end else begin
            read_data = regs[read_idx];
        end
    end

endmodule

// ==== verilog/retire_unit.sv ====
`timescale 1ns/100ps

module retire_unit import rob_pkg::*; #(
    parameter int ROB_DEPTH = 8  // passed to the rob
) (
    input  logic             clock,
    input  logic             rst_n,

    // dispatch
    input  logic             dispatch_valid,
    input  dispatch_packet_t dispatch_packet,
    output logic [TAG_W-1:0] dispatch_tag,
    output logic             rob_full,

    // completion
    input  complete_packet_t complete_packet,
    input  logic             complete_valid,

    // flush
    output logic             branch_mispredict,

    // retire, also written into the regfile
    output logic [XLEN-1:0]  retire_value,
    output reg_idx_t         retire_dest,
    output logic             retire_valid_out,
    output logic [XLEN-1:0]  mem_addr,
    output logic             mem_valid,

    // architectural read
    input  reg_idx_t         read_idx,
    output logic [XLEN-1:0]  read_data
);

    ////////////////////////////////////////
    // rob head to retire stage
    ////////////////////////////////////////

    rob_retire_packet_t rob_retire_packet;
    logic               rob_valid;
    logic               rob_ready;

    rob #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clock             (clock),
        .rst_n             (rst_n),
        .dispatch_valid    (dispatch_valid),
        .dispatch_packet   (dispatch_packet),
        .dispatch_tag      (dispatch_tag),
        .rob_full          (rob_full),
        .complete_valid    (complete_valid),
        .complete_packet   (complete_packet),
        .rob_retire_packet (rob_retire_packet),
        .rob_valid         (rob_valid),
        .rob_ready         (rob_ready),
        .branch_mispredict (branch_mispredict)
    );

    stage_rt u_stage_rt (
        .clock             (clock),
        .rst_n             (rst_n),
        .rob_retire_packet (rob_retire_packet),
        .rob_ready         (rob_ready),
        .rob_valid         (rob_valid),
        .branch_mispredict (branch_mispredict),
        .retire_value      (retire_value),
        .retire_dest       (retire_dest),
        .retire_valid_out  (retire_valid_out),
        .mem_addr          (mem_addr),
        .mem_valid         (mem_valid)
    );

    // retire outputs double as the write port
    regfile u_regfile (
        .clock      (clock),
        .rst_n      (rst_n),
        .write_en   (retire_valid_out),
        .write_idx  (retire_dest),
        .write_data (retire_value),
        .read_idx   (read_idx),
        .read_data  (read_data)
    );

endmodule

// ==== sim/retire_unit_assertions.sv ====
`timescale 1ns/100ps

module retire_unit_assertions import rob_pkg::*; (
    input logic         clock,
    input logic         rst_n,
    input logic         rob_valid,
    input logic         rob_ready,
    input logic         rob_full,
    input logic         branch_mispredict,
    input entry_state_e tail_state          // slot the next dispatch would take
);

    ////////////////////////////////////////
    // rob head and flush protocol
    ////////////////////////////////////////

    // a done head is always an occupied head
    ready_needs_valid: assert property (
        @(posedge clock) disable iff (!rst_n) rob_ready |-> rob_valid
    ) else $error("rob_ready high while the rob is empty");

    mispredict_one_cycle: assert property (
        @(posedge clock) disable iff (!rst_n) branch_mispredict |=> !branch_mispredict
    ) else $error("branch_mispredict held longer than one cycle");

    // a full rob has no free slot at the tail
    full_not_empty: assert property (
        @(posedge clock) disable iff (!rst_n)
            (rob_full && !branch_mispredict) |-> (tail_state != ENTRY_FREE)
    ) else $error("rob_full high while the tail slot is free");

endmodule

bind rob retire_unit_assertions u_assertions (
    .clock             (clock),
    .rst_n             (rst_n),
    .rob_valid         (rob_valid),
    .rob_ready         (rob_ready),
    .rob_full          (rob_full),
    .branch_mispredict (branch_mispredict),
    .tail_state        (entry_state[tail_idx])
);

// ==== sim/retire_unit_tb.sv ====
`timescale 1ns/100ps

module retire_unit_tb import rob_pkg::*; ();

    localparam int ROB_DEPTH  = 8;    // same depth as the dut
    localparam int WAIT_LIMIT = 200;  // cycles per wait loop

    logic             clock;
    logic             rst_n;
    logic             dispatch_valid;
    dispatch_packet_t dispatch_packet;
    logic [TAG_W-1:0] dispatch_tag;
    logic             rob_full;
    logic             complete_valid;
    complete_packet_t complete_packet;
    logic             branch_mispredict;
    logic [XLEN-1:0]  retire_value;
    reg_idx_t         retire_dest;
    logic             retire_valid_out;
    logic [XLEN-1:0]  mem_addr;
    logic             mem_valid;
    reg_idx_t         read_idx;
    logic [XLEN-1:0]  read_data;

    ////////////////////////////////////////
    // reference model state
    ////////////////////////////////////////

    rob_retire_packet_t exp_q [$];     // expected retires in dispatch order
    int                 seq_q [$];     // sequence number per expected retire
    complete_packet_t   pend_q [$];    // completions not sent yet
    int                 pend_seq [$];
    bit                 completed [0:4095];
    logic [XLEN-1:0]    model_regs [0:NUM_REGS-1];  // architectural state
    int                 next_seq;
    int                 errors;
    int                 test_errors;   // error count at test start
    int                 tests_passed;
    int                 tests_failed;
    string              cur_test;

    retire_unit #(
        .ROB_DEPTH (ROB_DEPTH)
    ) dut (
        .clock             (clock),
        .rst_n             (rst_n),
        .dispatch_valid    (dispatch_valid),
        .dispatch_packet   (dispatch_packet),
        .dispatch_tag      (dispatch_tag),
        .rob_full          (rob_full),
        .complete_packet   (complete_packet),
        .complete_valid    (complete_valid),
        .branch_mispredict (branch_mispredict),
        .retire_value      (retire_value),
        .retire_dest       (retire_dest),
        .retire_valid_out  (retire_valid_out),
        .mem_addr          (mem_addr),
        .mem_valid         (mem_valid),
        .read_idx          (read_idx),
        .read_data         (read_data)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;  // 10 ns period

    // what the retire stage must show for one instruction
    function automatic rob_retire_packet_t expected_retire(input dispatch_packet_t d,
                                                           input complete_packet_t c);
        rob_retire_packet_t p;
        p.value     = c.value;
        p.dest_reg  = d.dest_reg;
        p.mem_addr  = c.mem_addr;
        p.mem_valid = (d.op == OP_STORE);  // only stores drive the store strobe
        return p;
    endfunction

    function automatic logic [XLEN-1:0] random_word();
        return {$urandom, $urandom};
    endfunction

    function automatic reg_idx_t random_dest();
        return reg_idx_t'($urandom % NUM_REGS);  // x0 allowed
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s %s: expected 0x%0h, actual 0x%0h",
                     cur_test, name, expected, actual);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("error in %s: %s", cur_test, what);
    endtask

    task automatic abort_run(input string why);
        $display("timeout in %s: %s", cur_test, why);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic step();
        @(posedge clock);
        #1;  // drive just after the edge
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            tests_passed++;
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - test_errors);
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic dispatch_one(input rob_op_e op, input reg_idx_t dest, input logic mis,
                                input bit retires);
        dispatch_packet_t d;
        complete_packet_t c;
        int               cnt;
        cnt = 0;
        while (rob_full) begin  // source holds the instruction
            if (cnt == WAIT_LIMIT) begin
                abort_run("rob_full never dropped for a waiting dispatch");
            end
            step();
            cnt++;
        end
        d.op            = op;
        d.dest_reg      = dest;
        c.tag           = dispatch_tag;  // tag handed out this cycle
        c.value         = random_word();
        c.mem_addr      = (op == OP_STORE) ? random_word() : '0;
        c.mispredict    = mis;
        dispatch_valid  = 1'b1;
        dispatch_packet = d;
        pend_q.push_back(c);
        pend_seq.push_back(next_seq);
        if (retires) begin
            exp_q.push_back(expected_retire(d, c));
            seq_q.push_back(next_seq);
            if (dest != '0) begin
                model_regs[dest] = c.value;  // x0 never written
            end
        end
        next_seq++;
        step();
        dispatch_valid = 1'b0;
    endtask

    task automatic complete_one(input complete_packet_t c, input int s);
        complete_valid  = 1'b1;
        complete_packet = c;
        completed[s]    = 1'b1;
        step();
        complete_valid  = 1'b0;
    endtask

    // sends every pending completion in random order
    task automatic complete_random();
        complete_packet_t c;
        int               s;
        int               i;
        while (pend_q.size() > 0) begin
            i = int'($urandom % pend_q.size());
            c = pend_q[i];
            s = pend_seq[i];
            pend_q.delete(i);
            pend_seq.delete(i);
            complete_one(c, s);
        end
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0) begin
            if (cnt == WAIT_LIMIT) begin
                abort_run("expected instructions never retired");
            end
            step();
            cnt++;
        end
        step();  // last regfile write lands
    endtask

    task automatic check_regs();
        for (int i = 0; i < NUM_REGS; i++) begin
            read_idx = reg_idx_t'(i);
            #1;
            check($sformatf("x%0d", i), model_regs[i], read_data);
        end
        step();  // back in step with the clock
    endtask

    ////////////////////////////////////////
    // compare at mid cycle
    ////////////////////////////////////////

    always @(negedge clock) begin
        rob_retire_packet_t exp_p;
        int                 s;
        if (rst_n && retire_valid_out) begin
            if (exp_q.size() == 0) begin
                report_error($sformatf("unexpected retire to x%0d", retire_dest));
            end else begin
                exp_p = exp_q.pop_front();
                s     = seq_q.pop_front();
                if (!completed[s]) begin
                    report_error("instruction retired before its completion");
                end
                check("retire dest", 64'(exp_p.dest_reg), 64'(retire_dest));
                check("retire value", exp_p.value, retire_value);
                check("mem_valid", 64'(exp_p.mem_valid), 64'(mem_valid));
                check("mem_addr", exp_p.mem_addr, mem_addr);
            end
        end
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        complete_packet_t held_c;
        int               held_s;
        int               n;
        int               cnt;
        rob_op_e          op;
        logic [TAG_W-1:0] full_tag;
        void'($urandom(32'ha9c0c368));
        rst_n           = 1'b0;
        dispatch_valid  = 1'b0;
        dispatch_packet = '0;
        complete_valid  = 1'b0;
        complete_packet = '0;
        read_idx        = '0;
        next_seq        = 0;
        errors          = 0;
        test_errors     = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;

        begin_test("reset");
        check("rob_full", 64'd0, 64'(rob_full));
        check("branch_mispredict", 64'd0, 64'(branch_mispredict));
        check("retire_valid_out", 64'd0, 64'(retire_valid_out));
        check("mem_valid", 64'd0, 64'(mem_valid));
        check("dispatch_tag", 64'd0, 64'(dispatch_tag));
        check_regs();
        end_test();

        begin_test("in_order");
        for (int i = 0; i < ROB_DEPTH; i++) begin
            dispatch_one(OP_ALU, random_dest(), 1'b0, 1'b1);
        end
        complete_random();
        wait_drain();
        end_test();

        begin_test("stores");  // registers must stay as they are
        for (int i = 0; i < ROB_DEPTH; i++) begin
            dispatch_one(OP_STORE, '0, 1'b0, 1'b1);
        end
        complete_random();
        wait_drain();
        check_regs();
        end_test();

        begin_test("arch_state");
        for (int r = 0; r < 4; r++) begin
            n = 1 + int'($urandom % ROB_DEPTH);
            for (int i = 0; i < n; i++) begin
                op = ($urandom % 4 == 0) ? OP_STORE : OP_ALU;
                dispatch_one(op, (op == OP_STORE) ? reg_idx_t'(0) : random_dest(), 1'b0, 1'b1);
            end
            complete_random();
            wait_drain();
        end
        check_regs();
        end_test();

        begin_test("mispredict");
        dispatch_one(OP_BRANCH, reg_idx_t'(1 + $urandom % 31), 1'b1, 1'b1);
        for (int i = 0; i < 3; i++) begin
            dispatch_one(OP_ALU, reg_idx_t'(1 + $urandom % 31), 1'b0, 1'b0);  // flushed later
        end
        if (dispatch_tag == '0) begin
            // keep the unflushed tail off zero
            dispatch_one(OP_ALU, reg_idx_t'(1 + $urandom % 31), 1'b0, 1'b0);
        end
        held_c = pend_q.pop_front();  // branch completes last
        held_s = pend_seq.pop_front();
        complete_random();
        complete_one(held_c, held_s);
        cnt = 0;
        while (!branch_mispredict) begin
            if (cnt == WAIT_LIMIT) begin
                abort_run("branch_mispredict never pulsed");
            end
            step();
            cnt++;
        end
        check("branch retire with flush", 64'd1, 64'(retire_valid_out));
        step();
        check("branch_mispredict after one cycle", 64'd0, 64'(branch_mispredict));
        repeat (4) step();  // window for a stray younger retire
        check("retires left over", 64'd0, 64'(exp_q.size()));
        check_regs();
        check("tag after flush", 64'd0, 64'(dispatch_tag));
        dispatch_one(OP_ALU, random_dest(), 1'b0, 1'b1);
        complete_random();
        wait_drain();
        check_regs();
        end_test();

        begin_test("full");
        for (int i = 0; i < ROB_DEPTH; i++) begin
            dispatch_one(OP_ALU, random_dest(), 1'b0, 1'b1);
        end
        check("rob_full when filled", 64'd1, 64'(rob_full));
        full_tag                 = dispatch_tag;
        dispatch_valid           = 1'b1;  // must be ignored
        dispatch_packet.op       = OP_ALU;
        dispatch_packet.dest_reg = 5'd1;
        step();
        dispatch_valid = 1'b0;
        check("rob_full after extra dispatch", 64'd1, 64'(rob_full));
        check("tail held while full", 64'(full_tag), 64'(dispatch_tag));
        held_c = pend_q.pop_front();  // head first
        held_s = pend_seq.pop_front();
        complete_one(held_c, held_s);
        cnt = 0;
        while (rob_full) begin
            if (cnt == WAIT_LIMIT) begin
                abort_run("rob_full stayed high after the head retired");
            end
            step();
            cnt++;
        end
        complete_random();
        wait_drain();
        check_regs();
        end_test();

        $display("tests passed %0d, tests failed %0d, mismatches %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== retire_unit.f ====
verilog/rob_pkg.sv
verilog/rob.sv
verilog/stage_rt.sv
verilog/regfile.sv
verilog/retire_unit.sv
sim/retire_unit_assertions.sv
sim/retire_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module retire_unit_tb -f retire_unit.f --Mdir obj_dir

./obj_dir/Vretire_unit_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    exit 1
fi
exit 0
